// File: Bender.yml
package:
  name: ex_stage_top

sources:
  - include_dirs:
      - hw
    files:
      - hw/rv_ex_pkg.sv
      - hw/forwarding_unit.sv
      - hw/operand_select.sv
      - hw/alu.sv
      - hw/branch_control.sv
      - hw/execute.sv
      - hw/ex_pipeline_regs.sv
      - hw/ex_stage_top.sv
  - target: test
    include_dirs:
      - hw
    files:
      - testbench/tb_ex_stage_top.sv

// File: ex_stage_top.f
+incdir+hw
hw/rv_ex_pkg.sv
hw/forwarding_unit.sv
hw/operand_select.sv
hw/alu.sv
hw/branch_control.sv
hw/execute.sv
hw/ex_pipeline_regs.sv
hw/ex_stage_top.sv
testbench/tb_ex_stage_top.sv

// File: hw/alu.sv
`timescale 1ns/10ps
`include "rv_ex_cfg.svh"

module alu import rv_ex_pkg::*; (
    input  logic [`RV_ALU_CW-1:0] alu_ctrl,
    input  logic [`RV_XLEN-1:0]   alu_in_1,
    input  logic [`RV_XLEN-1:0]   alu_in_2,
    output logic [`RV_XLEN-1:0]   alu_result
);

    logic [4:0] shamt;
    logic       lt_signed;
    logic       lt_unsigned;

    // RV32 shifts only look at the low five bits
    assign shamt       = alu_in_2[4:0];
    assign lt_signed   = $signed(alu_in_1) < $signed(alu_in_2);
    assign lt_unsigned = alu_in_1 < alu_in_2;

    always_comb begin
        case (alu_ctrl)
            ALU_ADD:    alu_result = alu_in_1 + alu_in_2;
            ALU_SUB:    alu_result = alu_in_1 - alu_in_2;
            ALU_SLL:    alu_result = alu_in_1 << shamt;
            ALU_SLT:    alu_result = {{(`RV_XLEN-1){1'b0}}, lt_signed};
            ALU_SLTU:   alu_result = {{(`RV_XLEN-1){1'b0}}, lt_unsigned};
            ALU_XOR:    alu_result = alu_in_1 ^ alu_in_2;
            ALU_SRL:    alu_result = alu_in_1 >> shamt;
            ALU_SRA:    alu_result = $signed(alu_in_1) >>> shamt;
            ALU_OR:     alu_result = alu_in_1 | alu_in_2;
            ALU_AND:    alu_result = alu_in_1 & alu_in_2;
            ALU_PASS_B: alu_result = alu_in_2;
            default:    alu_result = '0;
        endcase
    end

endmodule

// File: hw/branch_control.sv
`timescale 1ns/10ps
`include "rv_ex_cfg.svh"

module branch_control import rv_ex_pkg::*; (
    input  logic [`RV_XLEN-1:0] op_a,
    input  logic [`RV_XLEN-1:0] op_b,
    input  logic [`RV_XLEN-1:0] pc,
    input  logic [`RV_XLEN-1:0] imm,
    input  logic [2:0]          branch_cond,
    input  logic                branch_valid,
    output logic                pc_src,
    output logic [`RV_XLEN-1:0] branch_target
);

    logic                taken;
    logic                is_jalr;
    logic [`RV_XLEN-1:0] base;
    logic [`RV_XLEN-1:0] sum;

    always_comb begin
        case (branch_cond)
            BR_BEQ:  taken = (op_a == op_b);
            BR_BNE:  taken = (op_a != op_b);
            BR_BLT:  taken = ($signed(op_a) < $signed(op_b));
            BR_BGE:  taken = ($signed(op_a) >= $signed(op_b));
            BR_BLTU: taken = (op_a < op_b);
            BR_BGEU: taken = (op_a >= op_b);
            // jal and jalr
            default: taken = 1'b1;
        endcase
    end

    assign pc_src  = branch_valid && taken;
    assign is_jalr = (branch_cond == BR_JALR);
    assign base    = is_jalr ? op_a : pc;
    assign sum     = base + imm;

    // jalr drops bit 0 of the computed address
    assign branch_target = {sum[`RV_XLEN-1:1], sum[0] & ~is_jalr};

endmodule

// File: hw/ex_pipeline_regs.sv
`timescale 1ns/10ps
`include "rv_ex_cfg.svh"

module ex_pipeline_regs import rv_ex_pkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,

    // Decoded instruction entering ID/EX
    input  logic                  id_valid,
    input  logic [`RV_XLEN-1:0]   id_rs1_data,
    input  logic [`RV_XLEN-1:0]   id_rs2_data,
    input  logic [`RV_XLEN-1:0]   id_imm,
    input  logic [`RV_XLEN-1:0]   id_pc,
    input  logic [`RV_REG_AW-1:0] id_rs1,
    input  logic [`RV_REG_AW-1:0] id_rs2,
    input  logic [`RV_REG_AW-1:0] id_rd,
    input  logic [`RV_ALU_CW-1:0] id_alu_ctrl,
    input  logic [1:0]            id_alu_src,
    input  logic [2:0]            id_branch_cond,
    input  logic                  id_branch_valid,
    input  logic [1:0]            id_result_src,
    input  logic                  id_mem_write,
    input  logic                  id_reg_write,
    input  logic                  squash,

    // Execute results entering EX/MEM
    input  logic [`RV_XLEN-1:0]   exe_alu_result,
    input  logic [`RV_XLEN-1:0]   exe_store_data,
    input  logic [`RV_REG_AW-1:0] exe_rd,
    input  logic [1:0]            exe_result_src,
    input  logic                  exe_mem_write,
    input  logic                  exe_reg_write,
    input  logic [`RV_XLEN-1:0]   exe_pc_plus4,
    input  logic [`RV_XLEN-1:0]   mem_load_data,

    // ID/EX
    output logic [`RV_XLEN-1:0]   ex_rs1_data,
    output logic [`RV_XLEN-1:0]   ex_rs2_data,
    output logic [`RV_XLEN-1:0]   ex_imm,
    output logic [`RV_XLEN-1:0]   ex_pc,
    output logic [`RV_REG_AW-1:0] ex_rs1,
    output logic [`RV_REG_AW-1:0] ex_rs2,
    output logic [`RV_REG_AW-1:0] ex_rd,
    output logic [`RV_ALU_CW-1:0] ex_alu_ctrl,
    output logic [1:0]            ex_alu_src,
    output logic [2:0]            ex_branch_cond,
    output logic                  ex_branch_valid,
    output logic [1:0]            ex_result_src,
    output logic                  ex_mem_write,
    output logic                  ex_reg_write,

    // EX/MEM
    output logic [`RV_XLEN-1:0]   mem_alu_result,
    output logic [`RV_XLEN-1:0]   mem_store_data,
    output logic [`RV_REG_AW-1:0] mem_rd,
    output logic                  mem_write,
    output logic                  mem_reg_write,

    // MEM/WB
    output logic [`RV_XLEN-1:0]   wb_result,
    output logic [`RV_REG_AW-1:0] wb_rd,
    output logic                  wb_reg_write
);

    logic                bubble;
    logic [1:0]          mem_result_src;
    logic [`RV_XLEN-1:0] mem_pc_plus4;
    logic [`RV_XLEN-1:0] wb_next;

    // Taken branch in EX or no valid decode
    assign bubble = squash || !id_valid;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex_reg_write    <= 1'b0;
            ex_mem_write    <= 1'b0;
            ex_branch_valid <= 1'b0;
            mem_reg_write   <= 1'b0;
            mem_write       <= 1'b0;
            wb_reg_write    <= 1'b0;
        end else begin
            ex_reg_write    <= id_reg_write && !bubble;
            ex_mem_write    <= id_mem_write && !bubble;
            ex_branch_valid <= id_branch_valid && !bubble;
            mem_reg_write   <= exe_reg_write;
            mem_write       <= exe_mem_write;
            wb_reg_write    <= mem_reg_write;
        end
    end

    always_ff @(posedge clk) begin
        ex_rs1_data    <= id_rs1_data;
        ex_rs2_data    <= id_rs2_data;
        ex_imm         <= id_imm;
        ex_pc          <= id_pc;
        ex_rs1         <= id_rs1;
        ex_rs2         <= id_rs2;
        ex_rd          <= id_rd;
        ex_alu_ctrl    <= id_alu_ctrl;
        ex_alu_src     <= id_alu_src;
        ex_branch_cond <= id_branch_cond;
        ex_result_src  <= id_result_src;
        mem_alu_result <= exe_alu_result;
        mem_store_data <= exe_store_data;
        mem_rd         <= exe_rd;
        mem_result_src <= exe_result_src;
        mem_pc_plus4   <= exe_pc_plus4;
        wb_result      <= wb_next;
        wb_rd          <= mem_rd;
    end

    // Load data is only valid in the MEM cycle
    always_comb begin
        case (mem_result_src)
            RES_LOAD: wb_next = mem_load_data;
            RES_PC4:  wb_next = mem_pc_plus4;
            default:  wb_next = mem_alu_result;
        endcase
    end

    // Only a valid branch in EX may squash the next instruction
    assert property (@(posedge clk) disable iff (!rst_n) squash |-> ex_branch_valid)
        else $error("ex_pipeline_regs: squash raised without a valid branch in EX");

endmodule

// File: hw/ex_stage_top.sv
`timescale 1ns/10ps
`include "rv_ex_cfg.svh"

module ex_stage_top (
    input  logic                  clk,
    input  logic                  rst_n,

    input  logic                  id_valid,
    input  logic [`RV_XLEN-1:0]   id_rs1_data,
    input  logic [`RV_XLEN-1:0]   id_rs2_data,
    input  logic [`RV_XLEN-1:0]   id_imm,
    input  logic [`RV_XLEN-1:0]   id_pc,
    input  logic [`RV_REG_AW-1:0] id_rs1,
    input  logic [`RV_REG_AW-1:0] id_rs2,
    input  logic [`RV_REG_AW-1:0] id_rd,
    input  logic [`RV_ALU_CW-1:0] id_alu_ctrl,
    input  logic [1:0]            id_alu_src,
    input  logic [2:0]            id_branch_cond,
    input  logic                  id_branch_valid,
    input  logic [1:0]            id_result_src,
    input  logic                  id_mem_write,
    input  logic                  id_reg_write,
    input  logic [`RV_XLEN-1:0]   mem_load_data,

    output logic                  pc_src,
    output logic [`RV_XLEN-1:0]   branch_target,
    output logic [`RV_XLEN-1:0]   mem_alu_result,
    output logic [`RV_XLEN-1:0]   mem_store_data,
    output logic [`RV_REG_AW-1:0] mem_rd,
    output logic                  mem_write,
    output logic                  mem_reg_write,
    output logic [`RV_XLEN-1:0]   wb_result,
    output logic [`RV_REG_AW-1:0] wb_rd,
    output logic                  wb_reg_write
);

    // ID/EX fields
    logic [`RV_XLEN-1:0]   ex_rs1_data;
    logic [`RV_XLEN-1:0]   ex_rs2_data;
    logic [`RV_XLEN-1:0]   ex_imm;
    logic [`RV_XLEN-1:0]   ex_pc;
    logic [`RV_REG_AW-1:0] ex_rs1;
    logic [`RV_REG_AW-1:0] ex_rs2;
    logic [`RV_REG_AW-1:0] ex_rd;
    logic [`RV_ALU_CW-1:0] ex_alu_ctrl;
    logic [1:0]            ex_alu_src;
    logic [2:0]            ex_branch_cond;
    logic                  ex_branch_valid;
    logic [1:0]            ex_result_src;
    logic                  ex_mem_write;
    logic                  ex_reg_write;

    // Execute outputs headed for EX/MEM
    logic [`RV_XLEN-1:0]   exe_alu_result;
    logic [`RV_XLEN-1:0]   exe_store_data;
    logic [`RV_REG_AW-1:0] exe_rd;
    logic [1:0]            exe_result_src;
    logic                  exe_mem_write;
    logic                  exe_reg_write;
    logic [`RV_XLEN-1:0]   exe_pc_plus4;

    logic [1:0]            forward_a;
    logic [1:0]            forward_b;

    ex_pipeline_regs i_ex_pipeline_regs (
        .clk             (clk),
        .rst_n           (rst_n),
        .id_valid        (id_valid),
        .id_rs1_data     (id_rs1_data),
        .id_rs2_data     (id_rs2_data),
        .id_imm          (id_imm),
        .id_pc           (id_pc),
        .id_rs1          (id_rs1),
        .id_rs2          (id_rs2),
        .id_rd           (id_rd),
        .id_alu_ctrl     (id_alu_ctrl),
        .id_alu_src      (id_alu_src),
        .id_branch_cond  (id_branch_cond),
        .id_branch_valid (id_branch_valid),
        .id_result_src   (id_result_src),
        .id_mem_write    (id_mem_write),
        .id_reg_write    (id_reg_write),
        .squash          (pc_src),
        .exe_alu_result  (exe_alu_result),
        .exe_store_data  (exe_store_data),
        .exe_rd          (exe_rd),
        .exe_result_src  (exe_result_src),
        .exe_mem_write   (exe_mem_write),
        .exe_reg_write   (exe_reg_write),
        .exe_pc_plus4    (exe_pc_plus4),
        .mem_load_data   (mem_load_data),
        .ex_rs1_data     (ex_rs1_data),
        .ex_rs2_data     (ex_rs2_data),
        .ex_imm          (ex_imm),
        .ex_pc           (ex_pc),
        .ex_rs1          (ex_rs1),
        .ex_rs2          (ex_rs2),
        .ex_rd           (ex_rd),
        .ex_alu_ctrl     (ex_alu_ctrl),
        .ex_alu_src      (ex_alu_src),
        .ex_branch_cond  (ex_branch_cond),
        .ex_branch_valid (ex_branch_valid),
        .ex_result_src   (ex_result_src),
        .ex_mem_write    (ex_mem_write),
        .ex_reg_write    (ex_reg_write),
        .mem_alu_result  (mem_alu_result),
        .mem_store_data  (mem_store_data),
        .mem_rd          (mem_rd),
        .mem_write       (mem_write),
        .mem_reg_write   (mem_reg_write),
        .wb_result       (wb_result),
        .wb_rd           (wb_rd),
        .wb_reg_write    (wb_reg_write)
    );

    forwarding_unit i_forwarding_unit (
        .ex_rs1        (ex_rs1),
        .ex_rs2        (ex_rs2),
        .mem_rd        (mem_rd),
        .wb_rd         (wb_rd),
        .mem_reg_write (mem_reg_write),
        .wb_reg_write  (wb_reg_write),
        .forward_a     (forward_a),
        .forward_b     (forward_b)
    );

    execute i_execute (
        .ex_rs1_data     (ex_rs1_data),
        .ex_rs2_data     (ex_rs2_data),
        .ex_imm          (ex_imm),
        .ex_pc           (ex_pc),
        .ex_rd           (ex_rd),
        .ex_alu_ctrl     (ex_alu_ctrl),
        .ex_alu_src      (ex_alu_src),
        .ex_branch_cond  (ex_branch_cond),
        .ex_branch_valid (ex_branch_valid),
        .ex_result_src   (ex_result_src),
        .ex_mem_write    (ex_mem_write),
        .ex_reg_write    (ex_reg_write),
        .forward_a       (forward_a),
        .forward_b       (forward_b),
        .mem_out         (mem_alu_result),
        .wb_out          (wb_result),
        .pc_src          (pc_src),
        .branch_target   (branch_target),
        .alu_result      (exe_alu_result),
        .store_data      (exe_store_data),
        .rd              (exe_rd),
        .result_src      (exe_result_src),
        .mem_write       (exe_mem_write),
        .reg_write       (exe_reg_write),
        .pc_plus4        (exe_pc_plus4)
    );

endmodule

// File: hw/execute.sv
`timescale 1ns/10ps
`include "rv_ex_cfg.svh"

module execute (
    input  logic [`RV_XLEN-1:0]   ex_rs1_data,
    input  logic [`RV_XLEN-1:0]   ex_rs2_data,
    input  logic [`RV_XLEN-1:0]   ex_imm,
    input  logic [`RV_XLEN-1:0]   ex_pc,
    input  logic [`RV_REG_AW-1:0] ex_rd,
    input  logic [`RV_ALU_CW-1:0] ex_alu_ctrl,
    input  logic [1:0]            ex_alu_src,
    input  logic [2:0]            ex_branch_cond,
    input  logic                  ex_branch_valid,
    input  logic [1:0]            ex_result_src,
    input  logic                  ex_mem_write,
    input  logic                  ex_reg_write,

    // From the forwarding unit
    input  logic [1:0]            forward_a,
    input  logic [1:0]            forward_b,

    // Results fed back from MEM and WB
    input  logic [`RV_XLEN-1:0]   mem_out,
    input  logic [`RV_XLEN-1:0]   wb_out,

    output logic                  pc_src,
    output logic [`RV_XLEN-1:0]   branch_target,
    output logic [`RV_XLEN-1:0]   alu_result,
    output logic [`RV_XLEN-1:0]   store_data,
    output logic [`RV_REG_AW-1:0] rd,
    output logic [1:0]            result_src,
    output logic                  mem_write,
    output logic                  reg_write,
    output logic [`RV_XLEN-1:0]   pc_plus4
);

    logic [`RV_XLEN-1:0] op_a;
    logic [`RV_XLEN-1:0] op_b;
    logic [`RV_XLEN-1:0] alu_in_1;
    logic [`RV_XLEN-1:0] alu_in_2;

    assign rd         = ex_rd;
    assign result_src = ex_result_src;
    assign mem_write  = ex_mem_write;
    assign reg_write  = ex_reg_write;
    assign pc_plus4   = ex_pc + `RV_XLEN'd4;

    // Stores write the forwarded rs2, never the immediate
    assign store_data = op_b;

    operand_select i_operand_select (
        .forward_a (forward_a),
        .forward_b (forward_b),
        .alu_src   (ex_alu_src),
        .rs1_data  (ex_rs1_data),
        .rs2_data  (ex_rs2_data),
        .mem_out   (mem_out),
        .wb_out    (wb_out),
        .pc        (ex_pc),
        .imm       (ex_imm),
        .op_a      (op_a),
        .op_b      (op_b),
        .alu_in_1  (alu_in_1),
        .alu_in_2  (alu_in_2)
    );

    alu i_alu (
        .alu_ctrl   (ex_alu_ctrl),
        .alu_in_1   (alu_in_1),
        .alu_in_2   (alu_in_2),
        .alu_result (alu_result)
    );

    branch_control i_branch_control (
        .op_a          (op_a),
        .op_b          (op_b),
        .pc            (ex_pc),
        .imm           (ex_imm),
        .branch_cond   (ex_branch_cond),
        .branch_valid  (ex_branch_valid),
        .pc_src        (pc_src),
        .branch_target (branch_target)
    );

endmodule

// File: hw/forwarding_unit.sv
`timescale 1ns/10ps
`include "rv_ex_cfg.svh"

module forwarding_unit import rv_ex_pkg::*; (
    input  logic [`RV_REG_AW-1:0] ex_rs1,
    input  logic [`RV_REG_AW-1:0] ex_rs2,
    input  logic [`RV_REG_AW-1:0] mem_rd,
    input  logic [`RV_REG_AW-1:0] wb_rd,
    input  logic                  mem_reg_write,
    input  logic                  wb_reg_write,
    output logic [1:0]            forward_a,
    output logic [1:0]            forward_b
);

    logic mem_hit_a;
    logic mem_hit_b;
    logic wb_hit_a;
    logic wb_hit_b;

    // x0 is hardwired, so a write to it never forwards
    assign mem_hit_a = mem_reg_write && (mem_rd != '0) && (mem_rd == ex_rs1);
    assign mem_hit_b = mem_reg_write && (mem_rd != '0) && (mem_rd == ex_rs2);
    assign wb_hit_a  = wb_reg_write && (wb_rd != '0) && (wb_rd == ex_rs1);
    assign wb_hit_b  = wb_reg_write && (wb_rd != '0) && (wb_rd == ex_rs2);

    // Youngest producer wins
    assign forward_a = mem_hit_a ? FWD_MEM : (wb_hit_a ? FWD_WB : FWD_REG);
    assign forward_b = mem_hit_b ? FWD_MEM : (wb_hit_b ? FWD_WB : FWD_REG);

endmodule

// File: hw/operand_select.sv
`timescale 1ns/10ps
`include "rv_ex_cfg.svh"

module operand_select import rv_ex_pkg::*; (
    input  logic [1:0]          forward_a,
    input  logic [1:0]          forward_b,
    input  logic [1:0]          alu_src,
    input  logic [`RV_XLEN-1:0] rs1_data,
    input  logic [`RV_XLEN-1:0] rs2_data,
    input  logic [`RV_XLEN-1:0] mem_out,
    input  logic [`RV_XLEN-1:0] wb_out,
    input  logic [`RV_XLEN-1:0] pc,
    input  logic [`RV_XLEN-1:0] imm,
    output logic [`RV_XLEN-1:0] op_a,
    output logic [`RV_XLEN-1:0] op_b,
    output logic [`RV_XLEN-1:0] alu_in_1,
    output logic [`RV_XLEN-1:0] alu_in_2
);

    // Forwarding muxes
    always_comb begin
        case (forward_a)
            FWD_MEM: op_a = mem_out;
            FWD_WB:  op_a = wb_out;
            default: op_a = rs1_data;
        endcase
        case (forward_b)
            FWD_MEM: op_b = mem_out;
            FWD_WB:  op_b = wb_out;
            default: op_b = rs2_data;
        endcase
    end

    // auipc and jal take the PC, I-type and stores take the immediate
    assign alu_in_1 = alu_src[ALU_SRC_PC] ? pc : op_a;
    assign alu_in_2 = alu_src[ALU_SRC_IMM] ? imm : op_b;

    assert final (forward_a !== 2'b11 && forward_b !== 2'b11)
        else $error("operand_select: unused forward select code");

endmodule

// File: hw/rv_ex_cfg.svh
`ifndef RV_EX_CFG_SVH
`define RV_EX_CFG_SVH

// Data and PC width, RV32 only
`define RV_XLEN 32

// Register index width
`define RV_REG_AW 5

// ALU control field width
`define RV_ALU_CW 5

`endif

// File: hw/rv_ex_pkg.sv
`include "rv_ex_cfg.svh"

package rv_ex_pkg;

    // ALU operations, codes past ALU_PASS_B give zero
    localparam logic [`RV_ALU_CW-1:0] ALU_ADD    = 5'd0;
    localparam logic [`RV_ALU_CW-1:0] ALU_SUB    = 5'd1;
    localparam logic [`RV_ALU_CW-1:0] ALU_SLL    = 5'd2;
    localparam logic [`RV_ALU_CW-1:0] ALU_SLT    = 5'd3;
    localparam logic [`RV_ALU_CW-1:0] ALU_SLTU   = 5'd4;
    localparam logic [`RV_ALU_CW-1:0] ALU_XOR    = 5'd5;
    localparam logic [`RV_ALU_CW-1:0] ALU_SRL    = 5'd6;
    localparam logic [`RV_ALU_CW-1:0] ALU_SRA    = 5'd7;
    localparam logic [`RV_ALU_CW-1:0] ALU_OR     = 5'd8;
    localparam logic [`RV_ALU_CW-1:0] ALU_AND    = 5'd9;
    // lui
    localparam logic [`RV_ALU_CW-1:0] ALU_PASS_B = 5'd10;

    // Forward selects, 2'b11 unused
    localparam logic [1:0] FWD_REG = 2'b00;
    localparam logic [1:0] FWD_WB  = 2'b01;
    localparam logic [1:0] FWD_MEM = 2'b10;

    // Bit positions inside the ALU source field
    localparam int ALU_SRC_PC  = 0;
    localparam int ALU_SRC_IMM = 1;

    // Branch conditions, conditional ones follow funct3
    localparam logic [2:0] BR_BEQ  = 3'b000;
    localparam logic [2:0] BR_BNE  = 3'b001;
    localparam logic [2:0] BR_JAL  = 3'b010;
    localparam logic [2:0] BR_JALR = 3'b011;
    localparam logic [2:0] BR_BLT  = 3'b100;
    localparam logic [2:0] BR_BGE  = 3'b101;
    localparam logic [2:0] BR_BLTU = 3'b110;
    localparam logic [2:0] BR_BGEU = 3'b111;

    // Writeback result sources
    localparam logic [1:0] RES_ALU  = 2'b00;
    localparam logic [1:0] RES_LOAD = 2'b01;
    localparam logic [1:0] RES_PC4  = 2'b10;

endpackage

// File: testbench/tb_ex_stage_top.sv
`timescale 1ns/10ps
`include "rv_ex_cfg.svh"

module tb_ex_stage_top import rv_ex_pkg::*; ();

    localparam int NUM_INSTR     = 3000;
    localparam int RESET_TIMEOUT = 40;
    localparam int DRAIN_TIMEOUT = 20;

    typedef struct packed {
        logic                  tracked;
        logic [`RV_XLEN-1:0]   rs1_data;
        logic [`RV_XLEN-1:0]   rs2_data;
        logic [`RV_XLEN-1:0]   imm;
        logic [`RV_XLEN-1:0]   pc;
        logic [`RV_REG_AW-1:0] rs1;
        logic [`RV_REG_AW-1:0] rs2;
        logic [`RV_REG_AW-1:0] rd;
        logic [`RV_ALU_CW-1:0] alu_ctrl;
        logic [1:0]            alu_src;
        logic [2:0]            br_cond;
        logic                  br_valid;
        logic [1:0]            res_src;
        logic                  mem_write;
        logic                  reg_write;
        logic [`RV_XLEN-1:0]   alu_result;
        logic [`RV_XLEN-1:0]   store_data;
        logic [`RV_XLEN-1:0]   wb_value;
    } stage_t;

    logic                  clk;
    logic                  rst_n;
    logic                  id_valid;
    logic [`RV_XLEN-1:0]   id_rs1_data;
    logic [`RV_XLEN-1:0]   id_rs2_data;
    logic [`RV_XLEN-1:0]   id_imm;
    logic [`RV_XLEN-1:0]   id_pc;
    logic [`RV_REG_AW-1:0] id_rs1;
    logic [`RV_REG_AW-1:0] id_rs2;
    logic [`RV_REG_AW-1:0] id_rd;
    logic [`RV_ALU_CW-1:0] id_alu_ctrl;
    logic [1:0]            id_alu_src;
    logic [2:0]            id_branch_cond;
    logic                  id_branch_valid;
    logic [1:0]            id_result_src;
    logic                  id_mem_write;
    logic                  id_reg_write;
    logic [`RV_XLEN-1:0]   mem_load_data;
    logic                  pc_src;
    logic [`RV_XLEN-1:0]   branch_target;
    logic [`RV_XLEN-1:0]   mem_alu_result;
    logic [`RV_XLEN-1:0]   mem_store_data;
    logic [`RV_REG_AW-1:0] mem_rd;
    logic                  mem_write;
    logic                  mem_reg_write;
    logic [`RV_XLEN-1:0]   wb_result;
    logic [`RV_REG_AW-1:0] wb_rd;
    logic                  wb_reg_write;

    logic [31:0]         lfsr;
    logic [31:0]         regs [0:31];
    // Index 0 is EX, 1 is MEM, 2 is WB
    stage_t              stg [0:2];
    logic [`RV_XLEN-1:0] exp_op_a;
    logic [`RV_XLEN-1:0] exp_op_b;
    logic [`RV_XLEN-1:0] exp_alu;
    logic [`RV_XLEN-1:0] exp_target;
    logic                exp_taken;
    int                  errors;
    int                  cycles;
    int                  instrs;
    int                  squashes;

    ex_stage_top i_dut (.*);

    always #50 clk = ~clk;

    initial begin
        rst_n = 1'b0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

    // Galois form with taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        if (state[0])
            return (state >> 1) ^ 32'h80200003;
        return state >> 1;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < n; i++) begin
            value = {value[30:0], lfsr[0]};
            lfsr = lfsr_step(lfsr);
        end
        return value;
    endfunction

    function automatic logic signed_less(input logic [31:0] a, input logic [31:0] b);
        if (a[31] != b[31])
            return a[31];
        return a < b;
    endfunction

    function automatic logic [31:0] alu_model(input logic [4:0] op, input logic [31:0] a,
                                              input logic [31:0] b);
        logic [4:0] sh;
        sh = b[4:0];
        case (op)
            ALU_ADD:    return a + b;
            ALU_SUB:    return a + ~b + 32'd1;
            ALU_SLL:    return a << sh;
            ALU_SLT:    return {31'd0, signed_less(a, b)};
            ALU_SLTU:   return {31'd0, a < b};
            ALU_XOR:    return a ^ b;
            ALU_SRL:    return a >> sh;
            ALU_SRA:    return (a >> sh) | (a[31] ? ~(32'hFFFFFFFF >> sh) : 32'h0);
            ALU_OR:     return a | b;
            ALU_AND:    return a & b;
            ALU_PASS_B: return b;
            default:    return 32'h0;
        endcase
    endfunction

    function automatic logic cond_taken(input logic [2:0] cond, input logic [31:0] a,
                                        input logic [31:0] b);
        case (cond)
            BR_BEQ:  return a == b;
            BR_BNE:  return a != b;
            BR_BLT:  return signed_less(a, b);
            BR_BGE:  return !signed_less(a, b);
            BR_BLTU: return a < b;
            BR_BGEU: return !(a < b);
            default: return 1'b1;
        endcase
    endfunction

    // Youngest writer first and x0 never forwarded
    function automatic logic [31:0] fwd_value(input logic [4:0] idx, input logic [31:0] reg_val);
        if (idx != 0 && stg[1].reg_write && stg[1].rd == idx)
            return stg[1].alu_result;
        if (idx != 0 && stg[2].reg_write && stg[2].rd == idx)
            return stg[2].wb_value;
        return reg_val;
    endfunction

    function automatic logic pipeline_busy();
        logic busy;
        busy = (pc_src !== 1'b0) || (mem_write !== 1'b0) || (mem_reg_write !== 1'b0)
               || (wb_reg_write !== 1'b0);
        for (int i = 0; i < 3; i++)
            busy = busy | stg[i].reg_write | stg[i].mem_write | stg[i].br_valid;
        return busy;
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        $display("mismatch %s: expected %h, actual %h", name, expected, actual);
        errors++;
    endtask

    task automatic eval_ex();
        logic [31:0] in_1;
        logic [31:0] in_2;
        logic [31:0] sum;
        exp_op_a  = fwd_value(stg[0].rs1, stg[0].rs1_data);
        exp_op_b  = fwd_value(stg[0].rs2, stg[0].rs2_data);
        in_1      = stg[0].alu_src[0] ? stg[0].pc : exp_op_a;
        in_2      = stg[0].alu_src[1] ? stg[0].imm : exp_op_b;
        exp_alu   = alu_model(stg[0].alu_ctrl, in_1, in_2);
        exp_taken = stg[0].br_valid && cond_taken(stg[0].br_cond, exp_op_a, exp_op_b);
        if (stg[0].br_cond == BR_JALR) begin
            sum        = exp_op_a + stg[0].imm;
            exp_target = {sum[31:1], 1'b0};
        end else begin
            exp_target = stg[0].pc + stg[0].imm;
        end
    endtask

    task automatic check_outputs();
        if (pc_src !== exp_taken)
            report_mismatch("branch_pc_src", exp_taken, pc_src);
        if (stg[0].br_valid && branch_target !== exp_target)
            report_mismatch("branch_target", exp_target, branch_target);
        if (mem_write !== stg[1].mem_write)
            report_mismatch("enable_mem_write", stg[1].mem_write, mem_write);
        if (mem_reg_write !== stg[1].reg_write)
            report_mismatch("enable_mem_reg_write", stg[1].reg_write, mem_reg_write);
        if (stg[1].tracked && mem_alu_result !== stg[1].alu_result)
            report_mismatch("alu_result", stg[1].alu_result, mem_alu_result);
        if (stg[1].tracked && mem_store_data !== stg[1].store_data)
            report_mismatch("forward_store_data", stg[1].store_data, mem_store_data);
        if (stg[1].tracked && mem_rd !== stg[1].rd)
            report_mismatch("mem_rd", stg[1].rd, mem_rd);
        if (wb_reg_write !== stg[2].reg_write)
            report_mismatch("enable_wb_reg_write", stg[2].reg_write, wb_reg_write);
        if (stg[2].tracked && wb_result !== stg[2].wb_value)
            report_mismatch("writeback_select", stg[2].wb_value, wb_result);
        if (stg[2].tracked && wb_rd !== stg[2].rd)
            report_mismatch("wb_rd", stg[2].rd, wb_rd);
    endtask

    task automatic drive_instr(input logic allow_valid);
        logic [31:0] r;
        id_valid = allow_valid && (rand_bits(3) != 0);
        // Eight registers keep hazards frequent
        id_rs1      = rand_bits(3);
        id_rs2      = rand_bits(3);
        id_rd       = rand_bits(3);
        id_rs1_data = regs[id_rs1];
        id_rs2_data = regs[id_rs2];
        if (rand_bits(1)) begin
            r      = rand_bits(12);
            id_imm = {{20{r[11]}}, r[11:0]};
        end else begin
            id_imm = rand_bits(32);
        end
        r               = rand_bits(30);
        id_pc           = {r[29:0], 2'b00};
        id_alu_ctrl     = rand_bits(4);
        id_alu_src      = rand_bits(2);
        id_branch_valid = (rand_bits(2) == 0);
        id_branch_cond  = rand_bits(3);
        id_result_src   = rand_bits(2);
        id_mem_write    = (rand_bits(2) == 0);
        id_reg_write    = (rand_bits(2) != 0);
        mem_load_data   = rand_bits(32);
    endtask

    task automatic advance_model();
        stg[2] = stg[1];
        case (stg[1].res_src)
            RES_LOAD: stg[2].wb_value = mem_load_data;
            RES_PC4:  stg[2].wb_value = stg[1].pc + 32'd4;
            default:  stg[2].wb_value = stg[1].alu_result;
        endcase
        stg[1]            = stg[0];
        stg[1].alu_result = exp_alu;
        stg[1].store_data = exp_op_b;
        stg[0].tracked    = 1'b1;
        stg[0].rs1_data   = id_rs1_data;
        stg[0].rs2_data   = id_rs2_data;
        stg[0].imm        = id_imm;
        stg[0].pc         = id_pc;
        stg[0].rs1        = id_rs1;
        stg[0].rs2        = id_rs2;
        stg[0].rd         = id_rd;
        stg[0].alu_ctrl   = id_alu_ctrl;
        stg[0].alu_src    = id_alu_src;
        stg[0].br_cond    = id_branch_cond;
        stg[0].res_src    = id_result_src;
        stg[0].br_valid   = id_branch_valid && id_valid && !exp_taken;
        stg[0].mem_write  = id_mem_write && id_valid && !exp_taken;
        stg[0].reg_write  = id_reg_write && id_valid && !exp_taken;
        if (exp_taken)
            squashes++;
        if (id_valid)
            instrs++;
    endtask

    task automatic run_cycle(input logic allow_valid);
        @(negedge clk);
        cycles++;
        eval_ex();
        check_outputs();
        // Register file write of the WB instruction lands before the ID read
        if (stg[2].reg_write && stg[2].rd != 0)
            regs[stg[2].rd] = stg[2].wb_value;
        drive_instr(allow_valid);
        advance_model();
    endtask

    initial begin
        int waited;
        clk             = 1'b0;
        lfsr            = 32'd71;
        errors          = 0;
        cycles          = 0;
        instrs          = 0;
        squashes        = 0;
        id_valid        = 1'b0;
        id_rs1_data     = '0;
        id_rs2_data     = '0;
        id_imm          = '0;
        id_pc           = '0;
        id_rs1          = '0;
        id_rs2          = '0;
        id_rd           = '0;
        id_alu_ctrl     = '0;
        id_alu_src      = '0;
        id_branch_cond  = '0;
        id_branch_valid = 1'b0;
        id_result_src   = '0;
        id_mem_write    = 1'b0;
        id_reg_write    = 1'b0;
        mem_load_data   = '0;
        for (int i = 0; i < 3; i++)
            stg[i] = '0;
        regs[0] = '0;
        for (int i = 1; i < 32; i++)
            regs[i] = rand_bits(32);

        waited = 0;
        while (rst_n !== 1'b1 && waited < RESET_TIMEOUT) begin
            @(posedge clk);
            waited++;
        end
        if (rst_n !== 1'b1) begin
            $display("reset was not released within %0d cycles", RESET_TIMEOUT);
            errors++;
        end else begin
            for (int n = 0; n < 4; n++)
                run_cycle(1'b0);
            for (int n = 0; n < NUM_INSTR; n++)
                run_cycle(1'b1);
            waited = 0;
            while (pipeline_busy() && waited < DRAIN_TIMEOUT) begin
                run_cycle(1'b0);
                waited++;
            end
            if (pipeline_busy()) begin
                $display("pipeline did not drain within %0d cycles", DRAIN_TIMEOUT);
                errors++;
            end
            // Idle pipeline must keep every enable low
            for (int n = 0; n < 4; n++)
                run_cycle(1'b0);
        end

        $display("cycles %0d, instructions %0d, squashes %0d, errors %0d",
                 cycles, instrs, squashes, errors);
        if (errors == 0)
            $display("TB PASSED");
        else
            $display("TB FAILED");
        $finish;
    end

endmodule
